// File: Bender.yml
package:
  name: mel_filter_bank

sources:
  - source/mel_pkg.sv
  - source/mel_weight_rom.sv
  - source/mel_weight_mult.sv
  - source/mel_band_accum.sv
  - source/log_energy_lut.sv
  - source/mel_band_store.sv
  - source/mel_filter_bank.sv
  - target: test
    files:
      - test/tb_mel_filter_bank.sv

// File: filelist.f
source/mel_pkg.sv
source/mel_weight_rom.sv
source/mel_weight_mult.sv
source/mel_band_accum.sv
source/log_energy_lut.sv
source/mel_band_store.sv
source/mel_filter_bank.sv
test/tb_mel_filter_bank.sv

// File: source/log_energy_lut.sv
module log_energy_lut (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      band_valid,
    input  mel_pkg::band_sum_t        band,
    output logic                      log_valid,
    output logic                      log_first,
    output mel_pkg::log_band_t        log_energy
);
    import mel_pkg::*;

    logic [LEAD_W-1:0]     lead;     // index of the leading one
    logic [SUM_W-1:0]      shifted;  // leading one moved to the msb
    logic [LOG_FRAC_W-1:0] frac;
    log_band_t             log_d;

    always_comb begin
        lead = '0;
        for (int i = 0; i < SUM_W; i++) begin
            if (band.sum[i])
                lead = LEAD_W'(i);  // highest set bit wins
        end
        shifted = band.sum << (LEAD_W'(SUM_W - 1) - lead);
        frac    = shifted[SUM_W-2 -: LOG_FRAC_W];  // bits under the leading one, zero filled
        if (band.sum == '0)
            log_d = '0;
        else
            log_d = {{(LOG_W - LEAD_W - LOG_FRAC_W){1'b0}}, lead, frac};  // lead*256 + frac
    end

    ////////////////////
    // output register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            log_valid <= 1'b0;
            log_first <= 1'b0;
        end else begin
            log_valid <= band_valid;
            if (band_valid)
                log_first <= band.first_flag;
        end
    end

    always_ff @(posedge clk) begin
        if (band_valid)
            log_energy <= log_d;
    end

endmodule

// File: source/mel_band_accum.sv
module mel_band_accum (
    input  logic               clk,
    input  logic               reset,
    input  logic               prod_valid,
    input  mel_pkg::product_t  prod,
    output logic               band_valid,
    output mel_pkg::band_sum_t band
);
    import mel_pkg::*;

    logic [SUM_W-1:0] rise_q, fall_q;        // open rising and falling sums
    logic [SUM_W-1:0] rise_base, fall_base;  // sums after a frame start clear
    logic [SUM_W-1:0] rise_d, fall_d;
    logic [SUM_W-1:0] scaled_ext;
    logic [SUM_W-1:0] fall_add;              // power * (1 - w)
    logic             first_pend;            // waiting for the first edge of the frame

    always_comb begin
        rise_base  = prod.first_flag ? '0 : rise_q;  // no carry across frames
        fall_base  = prod.first_flag ? '0 : fall_q;
        scaled_ext = SUM_W'(prod.scaled);
        fall_add   = SUM_W'(prod.power) - scaled_ext;
        rise_d     = rise_q;
        fall_d     = fall_q;
        if (prod_valid) begin
            if (prod.edge_flag) begin
                rise_d = '0;                       // peak closes the rising side
                fall_d = rise_base + scaled_ext;   // and opens its falling side
            end else begin
                rise_d = rise_base + scaled_ext;
                fall_d = fall_base + fall_add;
            end
        end
    end

    ////////////////////
    // state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rise_q     <= '0;
            fall_q     <= '0;
            first_pend <= 1'b0;
            band_valid <= 1'b0;
        end else begin
            rise_q     <= rise_d;
            fall_q     <= fall_d;
            band_valid <= prod_valid & prod.edge_flag;  // one band per edge
            if (prod_valid && prod.edge_flag)
                first_pend <= 1'b0;
            else if (prod_valid && prod.first_flag)
                first_pend <= 1'b1;
        end
    end

    // finished band is the falling sum before the edge, edge adds 0 to it
    always_ff @(posedge clk) begin
        if (prod_valid && prod.edge_flag) begin
            band.sum        <= fall_base;
            band.first_flag <= first_pend | prod.first_flag;
        end
    end

    // weight never above 1.0 upstream, so power - product stays positive
    a_fall_nonneg: assert property (@(posedge clk) disable iff (reset)
        prod_valid |-> prod.scaled <= prod.power);

endmodule

// File: source/mel_band_store.sv
module mel_band_store (
    input  logic               clk,
    input  logic               reset,
    input  logic               log_valid,
    input  logic               log_first,
    input  mel_pkg::log_band_t log_energy,
    output logic               frame_valid,
    output mel_pkg::band_vec_t frame_bands
);
    import mel_pkg::*;

    band_vec_t             work;      // bands of the frame being built
    band_vec_t             work_nxt;
    logic [BAND_CNT_W-1:0] band_cnt;  // bands collected so far
    logic                  take;

    assign take     = log_valid & ~log_first;  // first edge of a frame is empty
    assign work_nxt = {log_energy, work[NUM_BANDS-1:1]};  // newest enters the top slot

    ////////////////////
    // collect and publish
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            work        <= '0;
            band_cnt    <= '0;
            frame_valid <= 1'b0;
            frame_bands <= '0;
        end else begin
            frame_valid <= 1'b0;
            if (log_valid && log_first) begin
                band_cnt <= '0;  // realign on every frame start
            end else if (take) begin
                work <= work_nxt;
                if (band_cnt == BAND_CNT_W'(NUM_BANDS - 1)) begin
                    band_cnt    <= '0;
                    frame_bands <= work_nxt;  // band 0 ends in slot 0
                    frame_valid <= 1'b1;
                end else begin
                    band_cnt <= band_cnt + 1'b1;
                end
            end
        end
    end

    // a frame start only follows a complete set of six bands
    a_frame_align: assert property (@(posedge clk) disable iff (reset)
        log_valid && log_first |-> band_cnt == '0);

endmodule

// File: source/mel_filter_bank.sv
module mel_filter_bank (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        sample_valid,
    input  logic [mel_pkg::POWER_W-1:0] sample_power,
    output logic                        frame_valid,
    output mel_pkg::band_vec_t          frame_bands
);
    import mel_pkg::*;

    ////////////////////
    // stage links
    logic          bin_valid;   // comb, same cycle as sample_valid
    weighted_bin_t bin;
    logic          prod_valid;  // +2
    product_t      prod;
    logic          band_valid;  // +3, edge bins only
    band_sum_t     band;
    logic          log_valid;   // +4
    logic          log_first;
    log_band_t     log_energy;

    mel_weight_rom weight_rom_inst (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample_power (sample_power),
        .bin_valid    (bin_valid),
        .bin          (bin)
    );

    mel_weight_mult weight_mult_inst (
        .clk        (clk),
        .reset      (reset),
        .bin_valid  (bin_valid),
        .bin        (bin),
        .prod_valid (prod_valid),
        .prod       (prod)
    );

    mel_band_accum band_accum_inst (
        .clk        (clk),
        .reset      (reset),
        .prod_valid (prod_valid),
        .prod       (prod),
        .band_valid (band_valid),
        .band       (band)
    );

    log_energy_lut log_lut_inst (
        .clk        (clk),
        .reset      (reset),
        .band_valid (band_valid),
        .band       (band),
        .log_valid  (log_valid),
        .log_first  (log_first),
        .log_energy (log_energy)
    );

    // +5, frame out
    mel_band_store band_store_inst (
        .clk         (clk),
        .reset       (reset),
        .log_valid   (log_valid),
        .log_first   (log_first),
        .log_energy  (log_energy),
        .frame_valid (frame_valid),
        .frame_bands (frame_bands)
    );

endmodule

// File: source/mel_pkg.sv
package mel_pkg;

    ////////////////////
    // frame and band geometry
    localparam int NUM_BINS   = 32;             // spectrum bins per frame
    localparam int NUM_BANDS  = 6;              // mel bands per frame
    localparam int NUM_SEGS   = NUM_BANDS + 1;  // slope segments between the band peaks
    localparam int SEG_LEN [NUM_SEGS] = '{2, 3, 3, 4, 5, 7, 8};  // bins per segment, sum 32

    // fixed point, weights are Q1.15
    localparam int UNITY_WEIGHT = 32768;
    localparam int Q_SHIFT      = 15;

    ////////////////////
    // widths
    localparam int POWER_W    = 24;
    localparam int SUM_W      = 32;
    localparam int LOG_W      = 16;
    localparam int WEIGHT_W   = 17;                  // holds 1.0 exactly
    localparam int PROD_W     = POWER_W + WEIGHT_W;  // full multiplier result
    localparam int BIN_W      = $clog2(NUM_BINS);
    localparam int SEG_W      = $clog2(NUM_SEGS);
    localparam int POS_W      = 4;                   // position 1..8 within a segment
    localparam int LEAD_W     = $clog2(SUM_W);       // leading one index
    localparam int LOG_FRAC_W = 8;                   // mantissa bits below the leading one
    localparam int BAND_CNT_W = $clog2(NUM_BANDS);

    typedef logic [WEIGHT_W-1:0] weight_t;
    typedef weight_t weight_tab_t [NUM_BINS];

    // weight of position k (1..len) on a slope, rounded to nearest
    function automatic weight_t seg_weight(input int k, input int len);
        return weight_t'((UNITY_WEIGHT * k + len / 2) / len);
    endfunction

    // walks the segment table once, one entry per bin
    function automatic weight_tab_t build_weight_tab();
        weight_tab_t tab;
        int          idx;
        idx = 0;
        for (int s = 0; s < NUM_SEGS; s++) begin
            for (int k = 1; k <= SEG_LEN[s]; k++) begin
                tab[idx] = seg_weight(k, SEG_LEN[s]);
                idx++;
            end
        end
        return tab;
    endfunction

    localparam weight_tab_t WEIGHT_TAB = build_weight_tab();

    ////////////////////
    // stage payloads
    typedef struct packed {
        logic [POWER_W-1:0] power;
        weight_t            weight;
        logic               edge_flag;   // last bin of a segment, peak of a band
        logic               first_flag;  // bin 0 of a frame
    } weighted_bin_t;

    typedef struct packed {
        logic [POWER_W-1:0] scaled;      // power * weight >> 15
        logic [POWER_W-1:0] power;
        logic               edge_flag;
        logic               first_flag;
    } product_t;

    typedef struct packed {
        logic [SUM_W-1:0] sum;
        logic             first_flag;    // empty sum of the first edge, dropped later
    } band_sum_t;

    typedef logic [LOG_W-1:0] log_band_t;
    typedef log_band_t [NUM_BANDS-1:0] band_vec_t;

endpackage

// File: source/mel_weight_mult.sv
module mel_weight_mult (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   bin_valid,
    input  mel_pkg::weighted_bin_t bin,
    output logic                   prod_valid,
    output mel_pkg::product_t      prod
);
    import mel_pkg::*;

    weighted_bin_t     op_q;       // stage 1 operands
    logic              op_valid;
    logic [PROD_W-1:0] full_prod;  // 24x17 unsigned

    assign full_prod = op_q.power * op_q.weight;

    ////////////////////
    // valid pipe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_valid   <= 1'b0;
            prod_valid <= 1'b0;
        end else begin
            op_valid   <= bin_valid;
            prod_valid <= op_valid;
        end
    end

    // data pipe, flags ride along with the operands
    always_ff @(posedge clk) begin
        op_q <= bin;                                  // stage 1, register inputs
        prod.scaled     <= full_prod[Q_SHIFT +: POWER_W];  // stage 2, drop 15 fraction bits
        prod.power      <= op_q.power;
        prod.edge_flag  <= op_q.edge_flag;
        prod.first_flag <= op_q.first_flag;
    end

endmodule

// File: source/mel_weight_rom.sv
module mel_weight_rom (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        sample_valid,
    input  logic [mel_pkg::POWER_W-1:0] sample_power,
    output logic                        bin_valid,
    output mel_pkg::weighted_bin_t      bin
);
    import mel_pkg::*;

    logic [BIN_W-1:0] bin_cnt;  // bin index within the frame
    logic [SEG_W-1:0] seg_cnt;  // current slope segment
    logic [POS_W-1:0] pos_cnt;  // 1-based position in the segment
    logic             at_edge;

    assign at_edge = (pos_cnt == POS_W'(SEG_LEN[seg_cnt]));

    ////////////////////
    // counters advance once per strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bin_cnt <= '0;
            seg_cnt <= '0;
            pos_cnt <= POS_W'(1);
        end else if (sample_valid) begin
            if (bin_cnt == BIN_W'(NUM_BINS - 1)) begin  // frame wrap
                bin_cnt <= '0;
                seg_cnt <= '0;
                pos_cnt <= POS_W'(1);
            end else begin
                bin_cnt <= bin_cnt + 1'b1;
                if (at_edge) begin
                    seg_cnt <= seg_cnt + 1'b1;  // next slope
                    pos_cnt <= POS_W'(1);
                end else begin
                    pos_cnt <= pos_cnt + 1'b1;
                end
            end
        end
    end

    // tag the sample as it passes, no register here
    always_comb begin
        bin_valid      = sample_valid;
        bin.power      = sample_power;
        bin.weight     = WEIGHT_TAB[bin_cnt];
        bin.edge_flag  = at_edge;
        bin.first_flag = (bin_cnt == '0);
    end

    // table and segment counters must agree on where the peaks are
    a_edge_unity: assert property (@(posedge clk) disable iff (reset)
        bin_valid && bin.edge_flag |-> bin.weight == WEIGHT_W'(UNITY_WEIGHT));

endmodule

// File: test/tb_mel_filter_bank.sv
module tb_mel_filter_bank;
    import mel_pkg::*;

    localparam logic [31:0] SEED = 32'hf90a7761;
    localparam int LATENCY       = 5;                             // bin 31 strobe to frame_valid
    localparam int MAX_GAP       = 3;                             // idle cycles between bins
    localparam int FRAME_CYCLES  = NUM_BINS * (MAX_GAP + 1) + 8;  // worst frame plus drain
    localparam int TOTAL_FRAMES  = 1 + NUM_BINS + 1 + 8 + 2;      // zero, single, const, random, carry
    localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * FRAME_CYCLES + 200;

    logic               clk;
    logic               reset;
    logic               sample_valid;
    logic [POWER_W-1:0] sample_power;
    logic               frame_valid;
    band_vec_t          frame_bands;

    int                 cycle_cnt = 0;
    logic [31:0]        rng_state;
    int                 tests_run, tests_failed, error_cnt, test_errs;
    logic [POWER_W-1:0] frame_pw [NUM_BINS];  // frame being built by a test

    band_vec_t exp_q[$];      // model results in send order
    int        last_q[$];     // cycle at which bin 31 was driven
    band_vec_t got_q[$];      // frames seen on the output
    int        got_cyc_q[$];

    mel_filter_bank mel_filter_bank_inst (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample_power (sample_power),
        .frame_valid  (frame_valid),
        .frame_bands  (frame_bands)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////
    // cycle count and run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // outputs sampled mid cycle, well away from the edge
    always @(negedge clk) begin
        if (frame_valid) begin
            got_q.push_back(frame_bands);
            got_cyc_q.push_back(cycle_cnt);
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;  // numerical recipes lcg
        return rng_state;
    endfunction

    // leading one index times 256 plus the next 8 bits down
    function automatic log_band_t log2_approx(input longint v);
        int     lead;
        longint frac;
        if (v == 0)
            return '0;
        lead = 0;
        for (int i = 0; i < SUM_W; i++)
            if (v[i])
                lead = i;
        if (lead >= 8)
            frac = (v >> (lead - 8)) & 255;
        else
            frac = (v << (8 - lead)) & 255;  // zero fill below bit 0
        return log_band_t'(lead * 256 + frac);
    endfunction

    ////////////////////
    // reference model of the band and log rules
    task automatic model_frame(output band_vec_t exp_bands);
        longint sums [NUM_BANDS];
        longint w;
        longint part;
        int     idx;
        idx = 0;
        for (int b = 0; b < NUM_BANDS; b++)
            sums[b] = 0;
        for (int s = 0; s < NUM_SEGS; s++) begin
            for (int k = 1; k <= SEG_LEN[s]; k++) begin
                w    = (2 * UNITY_WEIGHT * k + SEG_LEN[s]) / (2 * SEG_LEN[s]);  // nearest
                part = (longint'(frame_pw[idx]) * w) >> 15;
                if (s < NUM_BANDS)
                    sums[s] += part;                          // rising side, peak included
                if (s > 0 && k < SEG_LEN[s])
                    sums[s-1] += longint'(frame_pw[idx]) - part;  // falling side
                idx++;
            end
        end
        for (int b = 0; b < NUM_BANDS; b++)
            exp_bands[b] = log2_approx(sums[b]);
    endtask

    // drives frame_pw, random idle gaps up to max_gap
    task automatic send_frame(input int max_gap);
        band_vec_t   exp_bands;
        logic [31:0] r;
        int          gap;
        model_frame(exp_bands);
        exp_q.push_back(exp_bands);
        for (int i = 0; i < NUM_BINS; i++) begin
            sample_valid = 1'b1;
            sample_power = frame_pw[i];
            if (i == NUM_BINS - 1)
                last_q.push_back(cycle_cnt);
            @(posedge clk);
            #1;
            sample_valid = 1'b0;
            r   = next_rand();
            gap = (max_gap == 0) ? 0 : int'(r[31:24]) % (max_gap + 1);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic start_test();
        test_errs = 0;
        tests_run++;
    endtask

    task automatic value_error(input string what, input int idx, input int got, input int exp);
        $display("error at %0t: %s %0d got %0h expected %0h", $time, what, idx, got, exp);
        test_errs++;
        error_cnt++;
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0)
            $display("test %-14s ok", name);
        else begin
            $display("test %-14s %0d errors", name, test_errs);
            tests_failed++;
        end
    endtask

    ////////////////////
    // waits for every sent frame, bounded, then compares in order
    task automatic check_frames();
        band_vec_t exp_b, got_b;
        int        waited, exp_c, got_c, n;
        waited = 0;
        while (got_q.size() < exp_q.size() && waited < FRAME_CYCLES) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (got_q.size() != exp_q.size()) begin
            $display("frame_valid count wrong, %0d frames sent but %0d seen",
                     exp_q.size(), got_q.size());
            test_errs++;
            error_cnt++;
        end
        n = 0;
        while (got_q.size() > 0 && exp_q.size() > 0) begin
            exp_b = exp_q.pop_front();
            got_b = got_q.pop_front();
            exp_c = last_q.pop_front() + LATENCY;
            got_c = got_cyc_q.pop_front();
            if (got_c != exp_c)
                value_error("frame_valid cycle of frame", n, got_c, exp_c);
            for (int b = 0; b < NUM_BANDS; b++)
                if (got_b[b] !== exp_b[b])
                    value_error("energy of band", b, got_b[b], exp_b[b]);
            n++;
        end
        exp_q.delete();
        last_q.delete();
        got_q.delete();
        got_cyc_q.delete();
    endtask

    ////////////////////
    // directed tests
    task automatic idle_after_reset();
        start_test();
        repeat (20) begin
            @(negedge clk);
            if (frame_valid !== 1'b0)
                value_error("frame_valid while idle, cycle", cycle_cnt, frame_valid, 0);
            if (frame_bands !== '0)
                value_error("frame_bands while idle, cycle", cycle_cnt, frame_bands[0], 0);
        end
        @(posedge clk);
        #1;
        finish_test("idle_after_reset");
    endtask

    task automatic zero_frame();
        start_test();
        foreach (frame_pw[i])
            frame_pw[i] = '0;
        send_frame(0);
        check_frames();
        finish_test("zero_frame");
    endtask

    // one full scale bin per frame, walked over all 32 positions
    task automatic single_bins();
        start_test();
        for (int pos = 0; pos < NUM_BINS; pos++) begin
            foreach (frame_pw[i])
                frame_pw[i] = (i == pos) ? {POWER_W{1'b1}} : '0;
            send_frame(0);
        end
        check_frames();
        finish_test("single_bins");
    endtask

    task automatic constant_frame();
        start_test();
        foreach (frame_pw[i])
            frame_pw[i] = 24'h123456;
        send_frame(MAX_GAP);
        check_frames();
        finish_test("constant_frame");
    endtask

    task automatic random_frames();
        logic [31:0] r;
        start_test();
        for (int f = 0; f < 8; f++) begin
            foreach (frame_pw[i]) begin
                r           = next_rand();
                frame_pw[i] = r[31:8];
            end
            send_frame((f < 4) ? MAX_GAP : 0);  // gapped first, then back to back
        end
        check_frames();
        finish_test("random_frames");
    endtask

    // loud frame then a quiet one, sums must restart
    task automatic frame_carry_over();
        start_test();
        foreach (frame_pw[i])
            frame_pw[i] = 24'hfff000;
        send_frame(0);
        foreach (frame_pw[i])
            frame_pw[i] = 24'd5 + i;
        send_frame(0);
        check_frames();
        finish_test("frame_carry_over");
    endtask

    initial begin
        reset        = 1'b1;
        sample_valid = 1'b0;
        sample_power = '0;
        rng_state    = SEED;
        tests_run    = 0;
        tests_failed = 0;
        error_cnt    = 0;
        test_errs    = 0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        idle_after_reset();
        zero_frame();
        single_bins();
        constant_frame();
        random_frames();
        frame_carry_over();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, error_cnt);
        if (error_cnt == 0 && tests_failed == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
